// ==== files.f ====
+incdir+.
fm_mix_pkg.sv
slot_if.sv
mix_regs.sv
slot_sequencer.sv
single_acc.sv
mix_acc.sv
fm_mix_top.sv
fm_mix_checker.sv
tb_fm_mix.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the FM mixer testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module tb_fm_mix \
    -o sim_fm_mix

# Keep running to the log check even if the simulator exits non-zero
./obj_dir/sim_fm_mix > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "All tests passed!" "$LOG"; then
    exit 0
else
    echo "Simulation did not pass, see $LOG"
    exit 1
fi

// ==== tb_fm_mix.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fm_mix_cfg.svh"

module tb_fm_mix;

    // 40 gapped frames, 102 register checks of two 3-cycle transfers, doubled
    localparam int TIMEOUT = (40 * `FM_SLOTS * 2 + 102 * 2 * 3) * 2;
    localparam bit MIX = (`FM_MIX_ADPCM != 0);

    logic clk = 1'b0;
    logic rst, clk_en, wb_we, wb_stb, wb_cyc, wb_ack, sample_valid;
    logic [3:0] wb_adr;
    logic [15:0] wb_dat_w, wb_dat_r;
    logic signed [`FM_OP_W-1:0] op_in;
    logic [2:0] cur_ch_out;
    logic [1:0] cur_op_out;
    logic signed [`FM_SND_W-1:0] left, right;

    int seed = 32'h54b7;
    int errors = 0, n_checked = 0, cycles = 0;
    bit running = 0;
    int op_mode = 0;                        // 0 random, 1 max, 2 min
    int alg_sh [0:7];                       // Shadow of the register file
    logic [1:0] rl_sh [0:7];
    int ada_l, ada_r, adb_l, adb_r;
    // Frame model state
    int codes [0:5] = '{0, 1, 2, 4, 5, 6};
    bit idle_done = 0, pend_valid = 0;
    int pend_ch, pend_op, pend_val, ch_idx = 0, op_n = 0;
    int sum_l = 0, sum_r = 0;
    int exp_l [$], exp_r [$];

    fm_mix_top dut_i (.*);

    always #4 clk = ~clk;

    function automatic bit is_carrier(int alg, int op);
        case (alg)
            4:       return op == 1 || op == 3;
            5, 6:    return op != 0;
            7:       return 1'b1;
            default: return op == 3;
        endcase
    endfunction

    function automatic int clamp16(int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    // What one slot adds to one side
    function automatic int contrib(int ch, int op, int val, bit is_left);
        bit rl_bit;
        if (op == 0 && ch == 2) return MIX ? (is_left ? ada_l : ada_r) * 4 : 0;
        if (op == 0 && ch == 6) return MIX ? (is_left ? adb_l : adb_r) >>> 1 : 0;
        rl_bit = is_left ? rl_sh[ch][1] : rl_sh[ch][0];
        return (is_carrier(alg_sh[ch], op) && rl_bit) ? val : 0;
    endfunction

    // Cycle limit for the whole run
    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout after %0d cycles, frames did not complete", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // Stimulus, model and output checks, all on the rising edge
    always @(posedge clk) begin
        if (!rst && clk_en) begin
            if (!idle_done) begin
                idle_done = 1;              // Sequencer leaves idle here
            end else begin
                if (pend_valid) begin
                    if (pend_ch == 0 && pend_op == 0) begin
                        exp_l.push_back(sum_l);     // Frame boundary
                        exp_r.push_back(sum_r);
                        sum_l = contrib(pend_ch, pend_op, pend_val, 1'b1);
                        sum_r = contrib(pend_ch, pend_op, pend_val, 1'b0);
                    end else begin
                        sum_l = clamp16(sum_l + contrib(pend_ch, pend_op, pend_val, 1'b1));
                        sum_r = clamp16(sum_r + contrib(pend_ch, pend_op, pend_val, 1'b0));
                    end
                end
                assert (cur_ch_out == codes[ch_idx] && cur_op_out == op_n)
                else begin
                    $display("[FAIL] %0t cur_ch_out/cur_op_out got %0d/%0d expected %0d/%0d",
                             $time, cur_ch_out, cur_op_out, codes[ch_idx], op_n);
                    errors++;
                end
                pend_ch = codes[ch_idx];
                pend_op = op_n;
                pend_val = int'(op_in);
                pend_valid = 1;
                op_n = (op_n + 1) % 4;
                if (op_n == 0) ch_idx = (ch_idx + 1) % 6;
            end
        end
        if (sample_valid) begin
            if (exp_l.size() == 0) begin
                $display("sample_valid at %0t with no frame expected", $time);
                errors++;
            end else begin
                assert (left == exp_l[0])
                else begin
                    $display("[FAIL] %0t left got %0d expected %0d", $time, left, exp_l[0]);
                    errors++;
                end
                assert (right == exp_r[0])
                else begin
                    $display("[FAIL] %0t right got %0d expected %0d", $time, right, exp_r[0]);
                    errors++;
                end
                void'(exp_l.pop_front());
                void'(exp_r.pop_front());
                n_checked++;
            end
        end
        clk_en <= running && (($random(seed) & 3) != 0);   // About 1 in 4 gaps
        case (op_mode)
            1:       op_in <= 14'sh1fff;
            2:       op_in <= -14'sh2000;
            default: op_in <= $random(seed);
        endcase
    end

    task automatic bus_xfer(input logic [3:0] adr, input logic [15:0] wdata,
                            input bit we, output logic [15:0] rdata);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= wdata;
        do @(posedge clk); while (!wb_ack);
        rdata = wb_dat_r;                   // Valid together with the ack
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic write_check(input logic [3:0] adr, input logic [15:0] wdata);
        logic [15:0] rd;
        bus_xfer(adr, wdata, 1'b1, rd);
        bus_xfer(adr, 16'h0, 1'b0, rd);
        assert (rd == wdata)
        else begin
            $display("[FAIL] %0t wb_dat_r@%h got %h expected %h", $time, adr, rd, wdata);
            errors++;
        end
    endtask

    task automatic set_channel(input int ch, input int alg, input logic [1:0] rl);
        write_check(4'(`FM_REG_CH0 + ch), {10'd0, rl, 1'b0, 3'(alg)});
        alg_sh[ch] = alg;
        rl_sh[ch] = rl;
    endtask

    task automatic set_adpcm();
        ada_l = $random(seed) % 8192;       // x4 still fits 16 bits
        ada_r = $random(seed) % 8192;
        adb_l = $random(seed) % 8192;
        adb_r = -($random(seed) & 16'h7fff);
        write_check(`FM_REG_ADPCMA, 16'(ada_l));
        write_check(`FM_REG_ADPCMA + 4'd1, 16'(ada_r));
        write_check(`FM_REG_ADPCMB, 16'(adb_l));
        write_check(`FM_REG_ADPCMB + 4'd1, 16'(adb_r));
    endtask

    task automatic run_frames(input int n);
        int target;
        target = n_checked + n;
        @(posedge clk);
        running <= 1'b1;
        while (n_checked < target) @(posedge clk);
        running <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    initial begin
        rst = 1'b1;
        clk_en = 1'b0;
        wb_we = 1'b0;
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
        wb_adr = 4'h0;
        wb_dat_w = 16'h0;
        op_in = '0;
        for (int i = 0; i < 8; i++) begin
            alg_sh[i] = 0;
            rl_sh[i] = 2'b00;
        end
        {ada_l, ada_r, adb_l, adb_r} = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // Register readback with random contents
        for (int i = 0; i < 6; i++)
            set_channel(codes[i], $random(seed) & 7, 2'($random(seed)));
        set_adpcm();
        // Every algorithm, rl pattern rotated per pass
        for (int a = 0; a < 8; a++) begin
            for (int i = 0; i < 6; i++)
                set_channel(codes[i], a, 2'((i + a) % 4));
            set_adpcm();
            run_frames(3);
        end
        // Saturation both ways
        for (int m = 1; m <= 2; m++) begin
            for (int i = 0; i < 6; i++)
                set_channel(codes[i], 7, 2'b11);
            op_mode = m;
            run_frames(3);
        end
        $display("Frames checked %0d, testbench errors %0d, assertion failures %0d",
                 n_checked, errors, dut_i.chk_i.fail_cnt);
        if (errors == 0 && dut_i.chk_i.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fm_mix_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_mix_checker (
    input wire       clk,
    input wire       rst,
    input wire       clk_en,
    input wire       wb_stb,
    input wire       wb_cyc,
    input wire       wb_ack,
    input wire       sample_valid,
    input wire [2:0] cur_ch_out,
    input wire [1:0] cur_op_out
);

    int fail_cnt = 0;       // Read by the testbench at the end

    // Ack only follows a live request
    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
    else begin
        fail_cnt++;
        $error("wb_ack without a request in the previous cycle");
    end

    // Open request answered on the very next clock
    ack_next_cycle: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
    else begin
        fail_cnt++;
        $error("wb_ack missing one cycle after a request");
    end

    // Ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
    else begin
        fail_cnt++;
        $error("wb_ack held longer than one cycle");
    end

    // Outputs quiet while in reset
    reset_quiet: assert property (@(posedge clk)
        rst |=> (!wb_ack && !sample_valid))
    else begin
        fail_cnt++;
        $error("wb_ack or sample_valid high during reset");
    end

    // Next slot ch 0 op 1 means the frame start slot is being mixed
    valid_after_frame: assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> $past(clk_en && cur_ch_out == 3'd0 && cur_op_out == 2'd1))
    else begin
        fail_cnt++;
        $error("sample_valid not preceded by an enabled frame start");
    end

endmodule

bind fm_mix_top fm_mix_checker chk_i (
    .clk          (clk),
    .rst          (rst),
    .clk_en       (clk_en),
    .wb_stb       (wb_stb),
    .wb_cyc       (wb_cyc),
    .wb_ack       (wb_ack),
    .sample_valid (sample_valid),
    .cur_ch_out   (cur_ch_out),
    .cur_op_out   (cur_op_out)
);

`default_nettype wire

// ==== fm_mix_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fm_mix_cfg.svh"

module fm_mix_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         clk_en,
    // Wishbone classic
    input  wire        [3:0]            wb_adr,
    input  wire        [15:0]           wb_dat_w,
    output logic       [15:0]           wb_dat_r,
    input  wire                         wb_we,
    input  wire                         wb_stb,
    input  wire                         wb_cyc,
    output logic                        wb_ack,
    // Operator stream
    input  wire signed [`FM_OP_W-1:0]   op_in,
    output logic       [2:0]            cur_ch_out,  // Slot taken on next enable
    output logic       [1:0]            cur_op_out,
    // Mixed audio
    output logic signed [`FM_SND_W-1:0] left,
    output logic signed [`FM_SND_W-1:0] right,
    output logic                        sample_valid
);
    import fm_mix_pkg::*;

    fm_alg_e                     ch_alg;
    logic [1:0]                  ch_rl;
    logic [2:0]                  cur_ch;
    logic signed [`FM_SND_W-1:0] adpcma_l;
    logic signed [`FM_SND_W-1:0] adpcma_r;
    logic signed [`FM_SND_W-1:0] adpcmb_l;
    logic signed [`FM_SND_W-1:0] adpcmb_r;

    slot_if slot_i ();

    // Lets the source present the matching operator
    assign {cur_ch_out, cur_op_out} =
        slot_i.slot_valid ? next_slot(slot_i.cur_ch, slot_i.cur_op) : 5'd0;

    mix_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_we    (wb_we),
        .wb_stb   (wb_stb),
        .wb_cyc   (wb_cyc),
        .wb_ack   (wb_ack),
        .cur_ch   (cur_ch),
        .ch_alg   (ch_alg),
        .ch_rl    (ch_rl),
        .adpcma_l (adpcma_l),
        .adpcma_r (adpcma_r),
        .adpcmb_l (adpcmb_l),
        .adpcmb_r (adpcmb_r)
    );

    slot_sequencer u_seq (
        .clk    (clk),
        .rst    (rst),
        .clk_en (clk_en),
        .op_in  (op_in),
        .slot   (slot_i.seq)
    );

    mix_acc u_acc (
        .clk          (clk),
        .rst          (rst),
        .clk_en       (clk_en),
        .slot         (slot_i.mix),
        .ch_alg       (ch_alg),
        .ch_rl        (ch_rl),
        .adpcma_l     (adpcma_l),
        .adpcma_r     (adpcma_r),
        .adpcmb_l     (adpcmb_l),
        .adpcmb_r     (adpcmb_r),
        .cur_ch       (cur_ch),
        .left         (left),
        .right        (right),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

// ==== mix_acc.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fm_mix_cfg.svh"

module mix_acc (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               clk_en,
    slot_if.mix                               slot,
    input  wire fm_mix_pkg::fm_alg_e          ch_alg,
    input  wire        [1:0]                  ch_rl,
    input  wire signed [`FM_SND_W-1:0]        adpcma_l,
    input  wire signed [`FM_SND_W-1:0]        adpcma_r,
    input  wire signed [`FM_SND_W-1:0]        adpcmb_l,
    input  wire signed [`FM_SND_W-1:0]        adpcmb_r,
    output logic       [2:0]                  cur_ch,    // Config lookup
    output logic signed [`FM_SND_W-1:0]       left,
    output logic signed [`FM_SND_W-1:0]       right,
    output logic                              sample_valid
);
    import fm_mix_pkg::*;

    localparam int W   = `FM_SND_W;
    localparam int OPW = `FM_OP_W;
    localparam bit MIX_ADPCM = (`FM_MIX_ADPCM != 0);

    logic                sum_en;        // Slot is a carrier for this algorithm
    logic signed [W-1:0] opext;
    logic signed [W-1:0] in_l;
    logic signed [W-1:0] in_r;
    logic                en_l;
    logic                en_r;

    assign cur_ch = slot.cur_ch;
    assign opext  = {{(W-OPW){slot.op_result[OPW-1]}}, slot.op_result};

    // Carriers per algorithm, op 0..3 = s1..s4
    always_comb begin
        case (ch_alg)
            ALG4:       sum_en = (slot.cur_op == 2'd1) || (slot.cur_op == 2'd3);
            ALG5, ALG6: sum_en = (slot.cur_op != 2'd0);   // All but s1
            ALG7:       sum_en = 1'b1;                    // Pure additive
            default:    sum_en = (slot.cur_op == 2'd3);   // ALG0..ALG3, s4 only
        endcase
    end

    // Channels 2 and 6 lend their s1 slot to ADPCM, FM data dropped
    always_comb begin
        case ({slot.cur_op, slot.cur_ch})
            {2'd0, 3'd2}: begin
                in_l = adpcma_l <<< 2;      // x4, wraps past 16 bits
                in_r = adpcma_r <<< 2;
                en_l = MIX_ADPCM;
                en_r = MIX_ADPCM;
            end
            {2'd0, 3'd6}: begin
                in_l = adpcmb_l >>> 1;      // Halved, sign kept
                in_r = adpcmb_r >>> 1;
                en_l = MIX_ADPCM;
                en_r = MIX_ADPCM;
            end
            default: begin
                in_l = opext;
                in_r = opext;
                en_l = sum_en && ch_rl[1];  // Left enable
                en_r = sum_en && ch_rl[0];  // Right enable
            end
        endcase
    end

    single_acc #(.W(W)) u_left (
        .clk       (clk),
        .rst       (rst),
        .clk_en    (clk_en),
        .acc_in    (in_l),
        .acc_en    (en_l && slot.slot_valid),
        .zero      (slot.zero),
        .snd       (left),
        .snd_valid (sample_valid)
    );

    // Same timing as left, its valid is not needed
    single_acc #(.W(W)) u_right (
        .clk       (clk),
        .rst       (rst),
        .clk_en    (clk_en),
        .acc_in    (in_r),
        .acc_en    (en_r && slot.slot_valid),
        .zero      (slot.zero),
        .snd       (right),
        .snd_valid ()
    );

endmodule

`default_nettype wire

// ==== single_acc.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fm_mix_cfg.svh"

module single_acc #(
    parameter int W = `FM_SND_W
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                clk_en,
    input  wire signed [W-1:0] acc_in,
    input  wire                acc_en,
    input  wire                zero,        // Frame start
    output logic signed [W-1:0] snd,        // Held for a whole frame
    output logic               snd_valid
);

    localparam logic signed [W-1:0] MAX_VAL = {1'b0, {(W-1){1'b1}}};
    localparam logic signed [W-1:0] MIN_VAL = {1'b1, {(W-1){1'b0}}};

    logic signed [W-1:0] acc;
    logic signed [W-1:0] addend;
    logic signed [W:0]   sum_wide;         // One guard bit
    logic signed [W-1:0] sum_sat;

    assign addend   = acc_en ? acc_in : '0;
    assign sum_wide = {acc[W-1], acc} + {addend[W-1], addend};

    // Clamp when the guard bit disagrees with the sign
    always_comb begin
        if (sum_wide[W] != sum_wide[W-1])
            sum_sat = sum_wide[W] ? MIN_VAL : MAX_VAL;
        else
            sum_sat = sum_wide[W-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc       <= '0;
            snd       <= '0;
            snd_valid <= 1'b0;
        end else begin
            snd_valid <= clk_en && zero;        // One clock per frame
            if (clk_en) begin
                if (zero) begin
                    snd <= acc;                 // Previous frame, already clamped
                    acc <= addend;              // New frame starts here
                end else begin
                    acc <= sum_sat;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== slot_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fm_mix_cfg.svh"

module slot_sequencer (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       clk_en,
    input  wire signed [`FM_OP_W-1:0] op_in,     // Result for the next slot
    slot_if.seq                       slot
);
    import fm_mix_pkg::*;

    seq_state_e state;
    logic [4:0] nxt;        // {ch, op} sampled on the next enabled edge

    // Start from ch 0 op 0 until a first slot is out
    assign nxt = slot.slot_valid ? next_slot(slot.cur_ch, slot.cur_op) : 5'd0;

    // Slot counters and frame marker
    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= SEQ_IDLE;
            slot.cur_ch     <= 3'd0;
            slot.cur_op     <= 2'd0;
            slot.zero       <= 1'b0;
            slot.slot_valid <= 1'b0;
        end else if (clk_en) begin
            case (state)
                SEQ_IDLE: begin
                    state <= SEQ_RUN;                // One enabled cycle of idle
                end
                SEQ_RUN: begin
                    slot.cur_ch     <= nxt[4:2];
                    slot.cur_op     <= nxt[1:0];
                    slot.zero       <= (nxt == 5'd0); // ch 0, op 0
                    slot.slot_valid <= 1'b1;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Operator sample moves with its slot fields
    always_ff @(posedge clk) begin
        if (clk_en && state == SEQ_RUN)
            slot.op_result <= op_in;
    end

endmodule

`default_nettype wire

// ==== mix_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fm_mix_cfg.svh"

module mix_regs (
    input  wire                              clk,
    input  wire                              rst,
    // Wishbone classic slave
    input  wire        [3:0]                 wb_adr,
    input  wire        [15:0]                wb_dat_w,
    output logic       [15:0]                wb_dat_r,
    input  wire                              wb_we,
    input  wire                              wb_stb,
    input  wire                              wb_cyc,
    output logic                             wb_ack,
    // Config lookup for the slot in the mixer
    input  wire        [2:0]                 cur_ch,
    output fm_mix_pkg::fm_alg_e              ch_alg,
    output logic       [1:0]                 ch_rl,
    output logic signed [`FM_SND_W-1:0]      adpcma_l,
    output logic signed [`FM_SND_W-1:0]      adpcma_r,
    output logic signed [`FM_SND_W-1:0]      adpcmb_l,
    output logic signed [`FM_SND_W-1:0]      adpcmb_r
);
    import fm_mix_pkg::*;

    localparam int RL_LSB = 4;      // Channel reg: alg in [2:0], rl in [5:4]

    fm_alg_e     alg_q [0:7];       // By channel code, 3 and 7 never written
    logic [1:0]  rl_q  [0:7];       // Bit 1 left, bit 0 right
    reg_addr_e   addr;
    logic [2:0]  reg_ch;            // Channel addressed by the bus
    logic        wb_hit;            // Request not yet acknowledged
    logic [15:0] rd_data;

    assign addr   = reg_addr_e'(wb_adr);
    assign reg_ch = 3'(wb_adr - `FM_REG_CH0);
    assign wb_hit = wb_cyc && wb_stb && !wb_ack;   // Ack drops it for one cycle

    // Fields of the slot being mixed
    assign ch_alg = alg_q[cur_ch];
    assign ch_rl  = rl_q[cur_ch];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                alg_q[i] <= ALG0;
                rl_q[i]  <= 2'b00;             // Muted
            end
            adpcma_l <= '0;
            adpcma_r <= '0;
            adpcmb_l <= '0;
            adpcmb_r <= '0;
        end else begin
            wb_ack <= wb_hit;                  // One cycle later, one cycle long
            if (wb_hit && wb_we) begin         // Write lands with the ack edge
                case (addr)
                    REG_CH0, REG_CH1, REG_CH2, REG_CH4, REG_CH5, REG_CH6: begin
                        alg_q[reg_ch] <= fm_alg_e'(wb_dat_w[2:0]);
                        rl_q[reg_ch]  <= wb_dat_w[RL_LSB +: 2];
                    end
                    REG_ADPCMA_L: adpcma_l <= wb_dat_w;
                    REG_ADPCMA_R: adpcma_r <= wb_dat_w;
                    REG_ADPCMB_L: adpcmb_l <= wb_dat_w;
                    REG_ADPCMB_R: adpcmb_r <= wb_dat_w;
                    default: ;                 // Holes ignore writes
                endcase
            end
        end
    end

    // Read mux
    always_comb begin
        rd_data = '0;
        case (addr)
            REG_CH0, REG_CH1, REG_CH2, REG_CH4, REG_CH5, REG_CH6: begin
                rd_data[2:0]         = alg_q[reg_ch];
                rd_data[RL_LSB +: 2] = rl_q[reg_ch];
            end
            REG_ADPCMA_L: rd_data = adpcma_l;
            REG_ADPCMA_R: rd_data = adpcma_r;
            REG_ADPCMB_L: rd_data = adpcmb_l;
            REG_ADPCMB_R: rd_data = adpcmb_r;
            default:      rd_data = '0;        // Holes read as zero
        endcase
    end

    // Read data goes out together with the ack
    always_ff @(posedge clk) begin
        if (wb_hit)
            wb_dat_r <= rd_data;
    end

endmodule

`default_nettype wire

// ==== slot_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fm_mix_cfg.svh"

// Slot timing plus operator sample, sequencer to mixer
interface slot_if;

    logic [2:0]                 cur_ch;      // Channel code 0-2, 4-6
    logic [1:0]                 cur_op;      // Operator 0..3, stands for s1..s4
    logic                       zero;        // First slot of a frame
    logic signed [`FM_OP_W-1:0] op_result;   // Registered operator output
    logic                       slot_valid;  // Fields above hold a real slot

    // Sequencer side drives everything
    modport seq (
        output cur_ch,
        output cur_op,
        output zero,
        output op_result,
        output slot_valid
    );

    // Mixer only listens
    modport mix (
        input cur_ch,
        input cur_op,
        input zero,
        input op_result,
        input slot_valid
    );

endinterface

`default_nettype wire

// ==== fm_mix_pkg.sv ====
`default_nettype none
`include "fm_mix_cfg.svh"

package fm_mix_pkg;

    // Operator connection algorithms, as in the chip's ALG field
    typedef enum logic [2:0] {
        ALG0, ALG1, ALG2, ALG3, ALG4, ALG5, ALG6, ALG7
    } fm_alg_e;

    // Register map, channel code 3 is a hole
    typedef enum logic [3:0] {
        REG_CH0      = `FM_REG_CH0,
        REG_CH1      = `FM_REG_CH0 + 4'd1,
        REG_CH2      = `FM_REG_CH0 + 4'd2,
        REG_CH4      = `FM_REG_CH0 + 4'd4,
        REG_CH5      = `FM_REG_CH0 + 4'd5,
        REG_CH6      = `FM_REG_CH0 + 4'd6,
        REG_ADPCMA_L = `FM_REG_ADPCMA,
        REG_ADPCMA_R = `FM_REG_ADPCMA + 4'd1,
        REG_ADPCMB_L = `FM_REG_ADPCMB,
        REG_ADPCMB_R = `FM_REG_ADPCMB + 4'd1
    } reg_addr_e;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

    // Slot after {ch, op}: operators 0..3, then channel 0,1,2,4,5,6 and wrap
    function automatic logic [4:0] next_slot(logic [2:0] ch, logic [1:0] op);
        logic [2:0] ch_n;
        case (ch)
            3'd2:    ch_n = 3'd4;           // Skip code 3
            3'd6:    ch_n = 3'd0;           // Frame wrap
            default: ch_n = ch + 3'd1;
        endcase
        if (op != 2'd3)
            return {ch, op + 2'd1};
        return {ch_n, 2'd0};
    endfunction

endpackage

`default_nettype wire

// ==== fm_mix_cfg.svh ====
`ifndef FM_MIX_CFG_SVH
`define FM_MIX_CFG_SVH

// Data path widths
`define FM_OP_W   14    // Operator result, signed
`define FM_SND_W  16    // Accumulators, outputs and ADPCM samples

`define FM_SLOTS  24    // 6 channels x 4 operators per frame

// ADPCM mixing switch
// 1 mixes ADPCM-A/B into their slots, 0 leaves those slots silent
`define FM_MIX_ADPCM 1

// Wishbone register map bases
`define FM_REG_CH0    4'h0  // Channel regs sit at base + channel code
`define FM_REG_ADPCMA 4'h8  // Left, then right
`define FM_REG_ADPCMB 4'hA  // Left, then right

`endif
